// File: project.f
source/pit_pkg.sv
source/pit_wb_decode.sv
source/pit_tclk_sync.sv
source/pit_counter.sv
source/pit_readback.sv
source/pit_top.sv
verification/pit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module pit_tb -o pit_sim
./obj_dir/pit_sim 2>&1 | tee sim.log
if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: source/pit_counter.sv
// one 8254-style binary counter, modes 2 and 3 only
// control word, reload register, latch and byte flip-flops on the wishbone side
module pit_counter #(
  parameter int unsigned CNT_IDX = 0
) (
  input  logic                      wb_clk_i,
  input  logic                      rst_n_i,
  input  pit_pkg::pit_access_t      access_i,
  input  logic                      tick_i,   // one bus cycle per tclk edge
  input  logic                      gate_i,   // synchronous to wb_clk_i
  output pit_pkg::pit_cnt_status_t  status_o
);

  localparam logic [1:0]  SC_CODE = 2'(CNT_IDX);
  localparam logic [1:0]  LANE    = pit_pkg::CNT_LANE[CNT_IDX];
  localparam logic [5:0]  CW_INIT = pit_pkg::CW0_DEFAULT[CNT_IDX];
  localparam logic [15:0] CR_INIT = pit_pkg::CR0_DEFAULT[CNT_IDX];

  logic [1:0]  cw_rw;     // stored access format
  logic [2:0]  cw_mode;   // 2 or 3
  logic [15:0] cr;        // reload value
  logic [15:0] cnt;       // down counter
  logic [15:0] latch_q;   // latched count
  logic        latched;
  logic [7:0]  wr_lsb;    // first byte of a word write
  logic        wr_msb;    // next write byte is msb
  logic        rd_msb;    // next read byte is msb
  logic        sq_q;      // mode 3 square wave level
  logic        load_pend; // load cr on next tick
  logic        gate_q;

  logic        ctrl_wr, cnt_wr, cnt_rd;
  logic [1:0]  rw_w;
  logic [2:0]  mode_w;
  logic        cw_latch, cw_store, wr_done, gate_rise;
  logic        term2, term3;
  logic [15:0] cr_next;
  logic [15:0] src;

  // control write reaches every counter, select field picks one
  assign ctrl_wr = access_i.wr && access_i.lane == pit_pkg::SEL_CTRL
                   && access_i.dat[pit_pkg::CW_SC_LSB +: 2] == SC_CODE;
  assign cnt_wr  = access_i.wr && access_i.lane == LANE;
  assign cnt_rd  = access_i.rd && access_i.lane == LANE;

  assign rw_w     = access_i.dat[pit_pkg::CW_RW_LSB +: 2];
  assign mode_w   = access_i.dat[pit_pkg::CW_MODE_LSB +: 3];
  assign cw_latch = ctrl_wr && rw_w == pit_pkg::RW_LATCH;
  assign cw_store = ctrl_wr && rw_w != pit_pkg::RW_LATCH && mode_w[1]; // 2,3,6,7 only

  // count write complete after the bytes its format needs
  assign wr_done   = cnt_wr && (cw_rw != pit_pkg::RW_WORD || wr_msb);
  assign gate_rise = gate_i & ~gate_q;

  assign term2 = (cnt == 16'd1);                     // mode 2 low phase
  assign term3 = (cnt == 16'd2) || (cnt == 16'd1);   // mode 3 half done, 1 when odd

  // single byte formats zero the other byte
  always_comb
  begin
    case (cw_rw)
      pit_pkg::RW_LSB: cr_next = {8'h00, access_i.dat};
      pit_pkg::RW_MSB: cr_next = {access_i.dat, 8'h00};
      default:         cr_next = {access_i.dat, wr_lsb}; // msb closes a word
    endcase
  end

  // control word, reload register and byte flip-flops
  always_ff @(posedge wb_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cw_rw   <= CW_INIT[pit_pkg::CW_RW_LSB +: 2];
      cw_mode <= CW_INIT[pit_pkg::CW_MODE_LSB +: 3];
      cr      <= CR_INIT;
      wr_msb  <= 1'b0;
      rd_msb  <= 1'b0;
      latched <= 1'b0;
    end
    else
    begin
      if (cw_store)
      begin
        cw_rw   <= rw_w;
        cw_mode <= {1'b0, mode_w[1:0]}; // 6 and 7 alias to 2 and 3
        wr_msb  <= 1'b0;
        rd_msb  <= 1'b0;
        latched <= 1'b0;
      end
      if (cw_latch && !latched)
        latched <= 1'b1; // repeat latch ignored until read out
      if (cnt_wr && cw_rw == pit_pkg::RW_WORD)
        wr_msb <= ~wr_msb;
      if (wr_done)
        cr <= cr_next;
      if (cnt_rd)
      begin
        if (cw_rw == pit_pkg::RW_WORD)
          rd_msb <= ~rd_msb;
        if (cw_rw != pit_pkg::RW_WORD || rd_msb)
          latched <= 1'b0; // fully read out
      end
    end
  end

  // data holding registers
  always_ff @(posedge wb_clk_i)
  begin
    if (cw_latch && !latched)
      latch_q <= cnt;
    if (cnt_wr && !wr_msb)
      wr_lsb <= access_i.dat;
  end

  // counting on tick under the gate
  always_ff @(posedge wb_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt       <= CR_INIT;
      sq_q      <= 1'b1;
      load_pend <= 1'b1; // defaults load on first tick
      gate_q    <= 1'b1;
    end
    else
    begin
      gate_q <= gate_i;
      if (!gate_i)
        sq_q <= 1'b1; // count held
      else if (tick_i)
      begin
        if (load_pend)
        begin
          cnt       <= cr;
          sq_q      <= 1'b1;
          load_pend <= 1'b0;
        end
        else if (!cw_mode[0])
          cnt <= term2 ? cr : cnt - 16'd1; // mode 2, period n
        else if (term3)
        begin
          sq_q <= ~sq_q;
          cnt  <= sq_q ? {cr[15:1], 1'b0} : cr; // low half gets the even part
        end
        else
          cnt <= cnt - 16'd2;
      end
      if (cw_store)
        sq_q <= 1'b1;
      if (wr_done || gate_rise)
        load_pend <= 1'b1; // wins over a load in the same cycle
    end
  end

  // read byte follows the stored format
  assign src = latched ? latch_q : cnt;

  always_comb
  begin
    case (cw_rw)
      pit_pkg::RW_MSB:  status_o.rd_byte = src[15:8];
      pit_pkg::RW_WORD: status_o.rd_byte = rd_msb ? src[15:8] : src[7:0];
      default:          status_o.rd_byte = src[7:0];
    endcase
    // gate low forces the output high at once
    status_o.out = !gate_i || (cw_mode[0] ? sq_q : !term2);
  end

  a_mode_legal: assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
      cw_mode inside {3'd2, 3'd3}
  ) else $error("counter %0d holds mode %0d", CNT_IDX, cw_mode);

endmodule

// File: source/pit_pkg.sv
// shared register map, control-word layout, reset defaults and bus structs
// for the three-counter interval timer, referenced by scoped name
package pit_pkg;

  localparam int NUM_CNT = 3;  // counters 0..2
  localparam int ADR_W   = 19; // wishbone word address, bits [19:1]

  // lane code is {wb_adr_i[1], wb_sel_i[1]}
  localparam logic [1:0] SEL_CNT0 = 2'b00; // counter 0, low byte
  localparam logic [1:0] SEL_CNT1 = 2'b01; // counter 1, high byte
  localparam logic [1:0] SEL_CNT2 = 2'b10; // counter 2, low byte
  localparam logic [1:0] SEL_CTRL = 2'b11; // control word, high byte

  // lane per counter index
  localparam logic [NUM_CNT-1:0][1:0] CNT_LANE = {SEL_CNT2, SEL_CNT1, SEL_CNT0};

  // access format field
  localparam logic [1:0] RW_LATCH = 2'b00; // counter latch command
  localparam logic [1:0] RW_LSB   = 2'b01;
  localparam logic [1:0] RW_MSB   = 2'b10;
  localparam logic [1:0] RW_WORD  = 2'b11; // lsb then msb

  // control word is sc[7:6] rw[5:4] mode[3:1] bcd[0]
  localparam int CW_SC_LSB   = 6;
  localparam int CW_RW_LSB   = 4;
  localparam int CW_MODE_LSB = 1;

  // reset control word without the select field
  localparam logic [NUM_CNT-1:0][5:0] CW0_DEFAULT = {
    6'h36,  // cnt2 speaker, word access, mode 3
    6'h14,  // cnt1 refresh, lsb access, mode 2
    6'h36   // cnt0 system tick, word access, mode 3
  };

  // reset reload values
  localparam logic [NUM_CNT-1:0][15:0] CR0_DEFAULT = {
    16'h04A9, // roughly 1 ms tone
    16'h0012, // roughly 15 us refresh
    16'hFFFF  // roughly 55 ms tick
  };

  // one decoded bus access, shared by all counters and the read mux
  typedef struct packed {
    logic       wr;   // acknowledged write
    logic       rd;   // acknowledged read
    logic [1:0] lane; // SEL_* code
    logic [7:0] dat;  // write byte taken from the lane's half
  } pit_access_t;

  // per-counter result toward the read mux
  typedef struct packed {
    logic [7:0] rd_byte; // byte a read would return now
    logic       out;     // counter output level
  } pit_cnt_status_t;

endpackage

// File: source/pit_readback.sv
// output side of the timer
// read data mux onto wb_dat_o and the system tick interrupt pulse
module pit_readback (
  input  logic                      wb_clk_i,
  input  logic                      rst_n_i,
  input  pit_pkg::pit_access_t      access_i,
  input  pit_pkg::pit_cnt_status_t  status0_i,
  input  pit_pkg::pit_cnt_status_t  status1_i,
  input  pit_pkg::pit_cnt_status_t  status2_i,
  output logic [15:0]               wb_dat_o,
  output logic                      wb_tgc_o
);

  logic out0_q; // counter 0 output, one cycle back

  // byte goes back on the lane it was asked on
  always_comb
  begin
    wb_dat_o = 16'h0000;
    if (access_i.rd)
    begin
      case (access_i.lane)
        pit_pkg::SEL_CNT0: wb_dat_o = {8'h00, status0_i.rd_byte};
        pit_pkg::SEL_CNT1: wb_dat_o = {status1_i.rd_byte, 8'h00};
        pit_pkg::SEL_CNT2: wb_dat_o = {8'h00, status2_i.rd_byte};
        default:           wb_dat_o = 16'h0000; // control lane is write only
      endcase
    end
  end

  // interrupt pulse on counter 0 rising output
  always_ff @(posedge wb_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out0_q   <= 1'b1; // outputs start high, no pulse out of reset
      wb_tgc_o <= 1'b0;
    end
    else
    begin
      out0_q   <= status0_i.out;
      wb_tgc_o <= status0_i.out & ~out0_q;
    end
  end

endmodule

// File: source/pit_tclk_sync.sv
// brings the slow asynchronous timer clock into the bus domain
// one-cycle tick_o per rising tclk_i edge, three bus cycles late
module pit_tclk_sync (
  input  logic wb_clk_i,
  input  logic rst_n_i,
  input  logic tclk_i,
  output logic tick_o
);

  logic sync1_q; // metastable stage
  logic sync2_q; // settled level
  logic prev_q;  // level one cycle back

  always_ff @(posedge wb_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      prev_q  <= 1'b0;
      tick_o  <= 1'b0;
    end
    else
    begin
      sync1_q <= tclk_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      tick_o  <= sync2_q & ~prev_q; // rising edge, registered
    end
  end

  // wb_clk_i is much faster than tclk_i so ticks never merge
  a_tick_single: assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
      tick_o |=> !tick_o
  ) else $error("tick held high for two bus cycles");

endmodule

// File: source/pit_top.sv
// three-counter interval timer as a wishbone slave for the x86 soc
// counter 0 ticks the system, counter 1 refresh, counter 2 the speaker
module pit_top (
  input  logic                     wb_clk_i,
  input  logic                     rst_n_i,
  input  logic [pit_pkg::ADR_W:1]  wb_adr_i,
  input  logic [1:0]               wb_sel_i,
  input  logic [15:0]              wb_dat_i,
  output logic [15:0]              wb_dat_o,
  input  logic                     wb_stb_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_we_i,
  output logic                     wb_ack_o,
  output logic                     wb_tgc_o, // system tick interrupt
  input  logic                     tclk_i,   // async timer clock
  input  logic                     gate2_i,  // speaker gate, bus synchronous
  output logic                     out2_o    // speaker
);

  pit_pkg::pit_access_t     access;
  pit_pkg::pit_cnt_status_t status0;
  pit_pkg::pit_cnt_status_t status1;
  pit_pkg::pit_cnt_status_t status2;
  logic                     tick;

  pit_wb_decode u_decode (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .access_o (access)
  );

  pit_tclk_sync u_sync (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .tclk_i   (tclk_i),
    .tick_o   (tick)
  );

  // counters 0 and 1 run ungated
  pit_counter #(.CNT_IDX(0)) u_cnt0 (
    .wb_clk_i (wb_clk_i), .rst_n_i (rst_n_i), .access_i (access),
    .tick_i   (tick),     .gate_i  (1'b1),    .status_o (status0)
  );

  pit_counter #(.CNT_IDX(1)) u_cnt1 (
    .wb_clk_i (wb_clk_i), .rst_n_i (rst_n_i), .access_i (access),
    .tick_i   (tick),     .gate_i  (1'b1),    .status_o (status1)
  );

  pit_counter #(.CNT_IDX(2)) u_cnt2 (
    .wb_clk_i (wb_clk_i), .rst_n_i (rst_n_i), .access_i (access),
    .tick_i   (tick),     .gate_i  (gate2_i), .status_o (status2)
  );

  pit_readback u_readback (
    .wb_clk_i  (wb_clk_i),
    .rst_n_i   (rst_n_i),
    .access_i  (access),
    .status0_i (status0),
    .status1_i (status1), // refresh level not used by the soc
    .status2_i (status2),
    .wb_dat_o  (wb_dat_o),
    .wb_tgc_o  (wb_tgc_o)
  );

  assign out2_o = status2.out;

endmodule

// File: source/pit_wb_decode.sv
// wishbone slave front end of the timer
// zero-wait acknowledge, lane code and byte steering into one access struct
module pit_wb_decode (
  input  logic                       wb_clk_i,
  input  logic                       rst_n_i,
  input  logic [pit_pkg::ADR_W:1]    wb_adr_i,  // only bit 1 matters here
  input  logic [1:0]                 wb_sel_i,
  input  logic [15:0]                wb_dat_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_we_i,
  output logic                       wb_ack_o,
  output pit_pkg::pit_access_t       access_o
);

  logic       acc_valid;
  logic [1:0] lane;
  logic [7:0] wr_byte;

  // no wait states, ack in the strobe cycle
  assign acc_valid = wb_stb_i & wb_cyc_i;
  assign wb_ack_o  = acc_valid;

  // upper address bits decoded by the soc interconnect
  assign lane = {wb_adr_i[1], wb_sel_i[1]};

  // odd lanes sit on the high byte
  always_comb
  begin
    case (lane)
      pit_pkg::SEL_CNT0: wr_byte = wb_dat_i[7:0];
      pit_pkg::SEL_CNT1: wr_byte = wb_dat_i[15:8];
      pit_pkg::SEL_CNT2: wr_byte = wb_dat_i[7:0];
      default:           wr_byte = wb_dat_i[15:8]; // control word
    endcase
  end

  always_comb
  begin
    access_o.wr   = acc_valid & wb_we_i;
    access_o.rd   = acc_valid & ~wb_we_i;
    access_o.lane = lane;
    access_o.dat  = wr_byte;
  end

  // lane code assumes exactly one byte select per access
  a_one_byte_lane: assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
      (wb_stb_i && wb_cyc_i) |-> (wb_sel_i == 2'b01 || wb_sel_i == 2'b10)
  ) else $error("timer access with sel %b, expected one byte lane", wb_sel_i);

endmodule

// File: verification/pit_tb.sv
// self-checking testbench for the wishbone interval timer
// replays the command lines of verification/pit_tests.txt against dut0
module pit_tb;

  logic                    wb_clk_i;
  logic                    rst_n_i;
  logic [pit_pkg::ADR_W:1] wb_adr_i;
  logic [1:0]              wb_sel_i;
  logic [15:0]             wb_dat_i;
  logic [15:0]             wb_dat_o;
  logic                    wb_stb_i;
  logic                    wb_cyc_i;
  logic                    wb_we_i;
  logic                    wb_ack_o;
  logic                    wb_tgc_o;
  logic                    tclk_i;
  logic                    gate2_i;
  logic                    out2_o;

  int tgc_total; // interrupt pulses since reset
  int tgc_seen;  // total at the last I command

  pit_top dut0 (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .wb_tgc_o (wb_tgc_o),
    .tclk_i   (tclk_i),
    .gate2_i  (gate2_i),
    .out2_o   (out2_o)
  );

  initial
  begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i; // period 4
  end

  // pulse lasts one cycle so each high sample is one interrupt
  always @(posedge wb_clk_i)
  begin
    if (!rst_n_i)
      tgc_total <= 0;
    else if (wb_tgc_o)
      tgc_total <= tgc_total + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // one wishbone cycle, odd lanes on the high byte
  task automatic bus_cycle(input logic [1:0] lane, input logic we,
                           input logic [7:0] wr_byte, output logic [15:0] rd_word);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge wb_clk_i);
    wb_adr_i <= {{(pit_pkg::ADR_W-1){1'b0}}, lane[1]};
    wb_sel_i <= lane[0] ? 2'b10 : 2'b01;
    wb_dat_i <= lane[0] ? {wr_byte, 8'h00} : {8'h00, wr_byte};
    wb_we_i  <= we;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    @(negedge wb_clk_i);
    while (!wb_ack_o)
    begin
      wait_cnt++;
      if (wait_cnt > 8)
        abort_run("no wishbone acknowledge within 8 cycles");
      @(negedge wb_clk_i);
    end
    check_val("wb_ack_o wait states", wait_cnt, 0); // ack in the strobe cycle
    rd_word = wb_dat_o;
    @(posedge wb_clk_i); // write lands on this edge
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  // tclk high 8 bus cycles then low 8, one tick each
  task automatic tclk_pulses(input int n);
    repeat (n)
    begin
      @(posedge wb_clk_i);
      tclk_i <= 1'b1;
      repeat (8) @(posedge wb_clk_i);
      tclk_i <= 1'b0;
      repeat (7) @(posedge wb_clk_i);
    end
  endtask

  initial
  begin
    int              fd;
    int              code;
    int              n_tok;
    int              a;
    int              b;
    logic [7:0]      op;
    logic [15:0]     rd_word;
    logic [15:0]     exp_word;
    logic [8*96-1:0] skip_line;
    rst_n_i   = 1'b0;
    wb_adr_i  = '0;
    wb_sel_i  = 2'b01;
    wb_dat_i  = 16'h0000;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    tclk_i    = 1'b0;
    gate2_i   = 1'b1;
    tgc_seen  = 0;
    n_tok     = 0;
    repeat (4) @(posedge wb_clk_i);
    rst_n_i <= 1'b1;
    fd = $fopen("verification/pit_tests.txt", "r");
    if (fd == 0)
      abort_run("cannot open verification/pit_tests.txt");
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%s", op);
      if (code != 1)
        break;
      n_tok++;
      if (n_tok > 500)
        abort_run("tests file runs past 500 commands");
      if (op == "#")
        code = $fgets(skip_line, fd); // rest of a comment line
      else if (op == "W" || op == "R")
        code = $fscanf(fd, "%h %h", a, b);
      else
        code = $fscanf(fd, "%h", a);
      case (op)
        "#": ;
        "W": bus_cycle(a[1:0], 1'b1, b[7:0], rd_word);
        "R":
        begin
          bus_cycle(a[1:0], 1'b0, 8'h00, rd_word);
          exp_word = a[0] ? {b[7:0], 8'h00} : {8'h00, b[7:0]}; // other byte zero
          check_val("wb_dat_o", {16'h0000, rd_word}, {16'h0000, exp_word});
        end
        "T": tclk_pulses(a);
        "G":
        begin
          @(posedge wb_clk_i);
          gate2_i <= a[0];
        end
        "O":
        begin
          @(negedge wb_clk_i);
          check_val("out2_o", {31'h0, out2_o}, {31'h0, a[0]});
        end
        "I":
        begin
          @(negedge wb_clk_i);
          check_val("wb_tgc_o pulses", tgc_total - tgc_seen, a);
          tgc_seen = tgc_total;
        end
        default: abort_run($sformatf("unknown command %s in tests file", op));
      endcase
    end
    $fclose(fd);
    if (n_tok == 0)
      abort_run("tests file holds no commands");
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: verification/pit_tests.txt
# op and hex values: W lane data, R lane byte, T pulses, G gate, O out2, I irq pulses
# lanes: 0 cnt0 low, 1 cnt1 high, 2 cnt2 low, 3 control high
# reset defaults of counter 2 through the latch
W 3 80
R 2 a9
R 2 04
# counter 2 mode 2 word 0123, five ticks
W 3 b4
W 2 23
W 2 01
T 5
W 3 80
R 2 1f
R 2 01
# counter 2 mode 3 count 4, half period 2 ticks
W 3 b6
W 2 04
W 2 00
T 2
O 1
T 1
O 0
T 1
O 0
T 1
O 1
# gate low while out is low, count held at 2, reload on gate rise
T 3
O 0
G 0
O 1
T 2
W 3 80
R 2 02
R 2 00
G 1
T 1
W 3 80
R 2 04
R 2 00
# counter 0 mode 2 count 3, ten ticks give three interrupts
I 0
W 3 34
W 0 03
W 0 00
T 0a
I 3
# counter 1 lsb only then msb only on the high lane
W 3 54
W 1 37
T 1
W 3 40
R 1 37
W 3 64
W 1 5a
T 2
R 1 59
